/* source/interp_pkg.sv */
/*
 * Attribute interpolator package
 * Widths, pipeline latencies, attribute indices and the packed
 * structs shared by the interpolator pipeline. Attributes are
 * signed fixed point and wrap modulo 2^ATTR_WIDTH.
 */
package interp_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    // Signed fixed-point attribute word
    localparam int ATTR_WIDTH = 32;

    // Screen and bounding-box coordinates
    localparam int SCREEN_POS_WIDTH = 11;

    // Framebuffer index
    localparam int INDEX_WIDTH = 32;

    localparam int NUM_ATTRS = 5;

    // Attribute slots in every per-attribute array
    localparam int ATTR_DEPTH_Z = 0;
    localparam int ATTR_COLOR_R = 1;
    localparam int ATTR_COLOR_G = 2;
    localparam int ATTR_COLOR_B = 3;
    localparam int ATTR_COLOR_A = 4;

    ////////////////////////////////////////////////////////////
    // Pipeline latencies, in clock edges
    ////////////////////////////////////////////////////////////

    localparam int MUL_LATENCY = 1;
    localparam int SUM_LATENCY = 2;
    localparam int INTERP_LATENCY = MUL_LATENCY + SUM_LATENCY;

    // In-flight counter covers one pixel more than the pipeline holds
    localparam int PIXEL_COUNT_WIDTH = $clog2(INTERP_LATENCY + 2);

    ////////////////////////////////////////////////////////////
    // Attribute types
    ////////////////////////////////////////////////////////////

    typedef logic signed [ATTR_WIDTH-1:0] attr_t;

    // Plane equation of one attribute, constant per triangle
    typedef struct packed {
        attr_t base;
        attr_t inc_x;
        attr_t inc_y;
    } attr_plane_t;

    typedef attr_plane_t [NUM_ATTRS-1:0] attr_plane_set_t;

    typedef attr_t [NUM_ATTRS-1:0] attr_set_t;

    // Step products along x and y for every attribute
    typedef struct packed {
        attr_set_t x;
        attr_set_t y;
    } attr_xy_set_t;

    ////////////////////////////////////////////////////////////
    // Pixel types
    ////////////////////////////////////////////////////////////

    // Pixel as delivered by the rasterizer
    typedef struct packed {
        logic                        valid;
        logic                        last;
        logic [SCREEN_POS_WIDTH-1:0] bbx;
        logic [SCREEN_POS_WIDTH-1:0] bby;
        logic [SCREEN_POS_WIDTH-1:0] spx;
        logic [SCREEN_POS_WIDTH-1:0] spy;
        logic [INDEX_WIDTH-1:0]      index;
    } pixel_in_t;

    // Fields passed through unchanged; bbx/bby end at the multiplier
    typedef struct packed {
        logic                        valid;
        logic                        last;
        logic [SCREEN_POS_WIDTH-1:0] spx;
        logic [SCREEN_POS_WIDTH-1:0] spy;
        logic [INDEX_WIDTH-1:0]      index;
    } pixel_sideband_t;

endpackage

/* source/pixel_tracker.sv */
/*
 * Pixel tracker
 * Counts pixels between input and output of the interpolator and
 * flags when any pixel is in flight.
 */
`timescale 1ns/1ns

module pixel_tracker
    import interp_pkg::*;
(
    input  logic aclk,
    input  logic reset,
    input  logic pixel_accepted,
    input  logic pixel_emitted,
    output logic pixel_in_pipeline
);

    logic [PIXEL_COUNT_WIDTH-1:0] pixel_count;

    always_ff @(posedge aclk) begin
        if (reset) begin
            pixel_count <= '0;
        end else begin
            case ({pixel_accepted, pixel_emitted})
                2'b10:   pixel_count <= pixel_count + 1'b1;
                2'b01:   pixel_count <= pixel_count - 1'b1;
                // Both or neither leave the count unchanged
                default: pixel_count <= pixel_count;
            endcase
        end
    end

    // A pixel entering this cycle counts as in flight already
    assign pixel_in_pipeline = (pixel_count != '0) || pixel_accepted;

endmodule

/* source/sideband_delay.sv */
/*
 * Sideband delay line
 * Shifts the pixel sideband through INTERP_LATENCY registers so it
 * leaves together with the interpolated attributes.
 */
`timescale 1ns/1ns

module sideband_delay
    import interp_pkg::*;
(
    input  logic            aclk,
    input  logic            reset,
    input  pixel_sideband_t sideband_in,
    output pixel_sideband_t sideband_out
);

    pixel_sideband_t stage [INTERP_LATENCY];

    always_ff @(posedge aclk) begin
        stage[0] <= sideband_in;
        for (int i = 1; i < INTERP_LATENCY; i++) begin
            stage[i] <= stage[i-1];
        end

        // Only the valid bits are cleared, payload keeps flowing
        if (reset) begin
            for (int i = 0; i < INTERP_LATENCY; i++) begin
                stage[i].valid <= 1'b0;
            end
        end
    end

    assign sideband_out = stage[INTERP_LATENCY-1];

endmodule

/* source/bbox_step_multiplier.sv */
/*
 * Bounding-box step multiplier
 * First pipeline stage. Scales the x and y increments of every
 * attribute by the pixel's bounding-box position and registers the
 * low ATTR_WIDTH bits of each product.
 */
`timescale 1ns/1ns

module bbox_step_multiplier
    import interp_pkg::*;
(
    input  logic                        aclk,

    // Position inside the triangle bounding box
    input  logic [SCREEN_POS_WIDTH-1:0] bbx,
    input  logic [SCREEN_POS_WIDTH-1:0] bby,

    input  attr_plane_set_t             planes,

    output attr_xy_set_t                products
);

    localparam int POS_PAD = ATTR_WIDTH - SCREEN_POS_WIDTH;

    attr_t bbx_ext;
    attr_t bby_ext;

    ////////////////////////////////////////////////////////////
    // Operand preparation
    ////////////////////////////////////////////////////////////

    // Positions are unsigned, so the upper bits are zero
    assign bbx_ext = attr_t'({{POS_PAD{1'b0}}, bbx});
    assign bby_ext = attr_t'({{POS_PAD{1'b0}}, bby});

    ////////////////////////////////////////////////////////////
    // Product registers
    ////////////////////////////////////////////////////////////

    // Result width equals ATTR_WIDTH, so products wrap modulo 2^32
    always_ff @(posedge aclk) begin
        for (int i = 0; i < NUM_ATTRS; i++) begin
            products.x[i] <= bbx_ext * planes[i].inc_x;
            products.y[i] <= bby_ext * planes[i].inc_y;
        end
    end

endmodule

/* source/attribute_summer.sv */
/*
 * Attribute summer
 * Second and third pipeline stages. Adds the x and y step products,
 * then adds the plane base. Every sum wraps modulo 2^ATTR_WIDTH.
 */
`timescale 1ns/1ns

module attribute_summer
    import interp_pkg::*;
(
    input  logic            aclk,

    // Step products from the multiplier
    input  attr_xy_set_t    products,

    input  attr_plane_set_t planes,

    output attr_set_t       attrs
);

    attr_set_t step_sum;

    ////////////////////////////////////////////////////////////
    // Stage 1: combined step
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        for (int i = 0; i < NUM_ATTRS; i++) begin
            step_sum[i] <= products.x[i] + products.y[i];
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 2: add base value
    ////////////////////////////////////////////////////////////

    // Planes are held stable, so no delayed copy of the base is needed
    always_ff @(posedge aclk) begin
        for (int i = 0; i < NUM_ATTRS; i++) begin
            attrs[i] <= step_sum[i] + planes[i].base;
        end
    end

endmodule

/* source/attribute_interpolator.sv */
/*
 * Attribute interpolator
 * Computes base + inc_x * bbx + inc_y * bby for depth and RGBA of
 * every rasterized pixel. Fully pipelined, one pixel per cycle,
 * no back-pressure. The sideband leaves aligned with the attributes.
 */
`timescale 1ns/1ns

module attribute_interpolator
    import interp_pkg::*;
(
    input  logic            aclk,
    input  logic            reset,

    // Pixel stream from the rasterizer
    input  pixel_in_t       pixel_in,

    // Triangle planes, stable while pixels are in flight
    input  attr_plane_set_t planes,

    // Interpolated pixel stream
    output pixel_sideband_t pixel_out,
    output attr_set_t       attrs_out,

    output logic            pixel_in_pipeline
);

    logic [SCREEN_POS_WIDTH-1:0] bbx;
    logic [SCREEN_POS_WIDTH-1:0] bby;
    pixel_sideband_t             sideband_in;
    attr_xy_set_t                products;

    ////////////////////////////////////////////////////////////
    // Split the incoming pixel
    ////////////////////////////////////////////////////////////

    // Bounding box feeds the arithmetic, the rest rides along
    assign bbx = pixel_in.bbx;
    assign bby = pixel_in.bby;

    always_comb begin
        sideband_in.valid = pixel_in.valid;
        sideband_in.last  = pixel_in.last;
        sideband_in.spx   = pixel_in.spx;
        sideband_in.spy   = pixel_in.spy;
        sideband_in.index = pixel_in.index;
    end

    ////////////////////////////////////////////////////////////
    // Arithmetic path
    ////////////////////////////////////////////////////////////

    bbox_step_multiplier step_mul (
        .aclk     (aclk),
        .bbx      (bbx),
        .bby      (bby),
        .planes   (planes),
        .products (products)
    );

    attribute_summer summer (
        .aclk     (aclk),
        .products (products),
        .planes   (planes),
        .attrs    (attrs_out)
    );

    ////////////////////////////////////////////////////////////
    // Pass-through and in-flight tracking
    ////////////////////////////////////////////////////////////

    sideband_delay sideband_pipe (
        .aclk         (aclk),
        .reset        (reset),
        .sideband_in  (sideband_in),
        .sideband_out (pixel_out)
    );

    // No ready signals, so every valid beat is a transfer
    pixel_tracker tracker (
        .aclk              (aclk),
        .reset             (reset),
        .pixel_accepted    (pixel_in.valid),
        .pixel_emitted     (pixel_out.valid),
        .pixel_in_pipeline (pixel_in_pipeline)
    );

endmodule

/* tb/tb_clock_gen.sv */
/*
 * Testbench clock and reset
 * 8 ns clock, synchronous reset held high for the first 4 rising edges.
 */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic aclk,
    output logic reset
);

    localparam int HALF_PERIOD = 4;
    localparam int RESET_CYCLES = 4;

    initial begin
        aclk = 1'b0;
        forever #HALF_PERIOD aclk = ~aclk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        reset <= 1'b0;
    end

endmodule

/* tb/tb_attribute_interpolator.sv */
/*
 * Attribute interpolator testbench
 * Directed tests for reset state, single pixel, back-to-back stream,
 * wrap-around and the in-flight flag. A monitor compares every output
 * beat against a queue filled by the reference model.
 */
`timescale 1ns/1ns

module tb_attribute_interpolator
    import interp_pkg::*;
();

    localparam int EXPECTED_LATENCY = 3;
    localparam int RESET_TIMEOUT = 20;
    localparam int DRAIN_TIMEOUT = 50;
    localparam int STREAM_LENGTH = 20;

    typedef logic [SCREEN_POS_WIDTH-1:0] pos_t;

    // One expected output beat
    typedef struct packed {
        pixel_sideband_t sideband;
        attr_set_t       attrs;
    } expected_pixel_t;

    logic            aclk;
    logic            reset;
    pixel_in_t       pixel_in;
    attr_plane_set_t planes;
    pixel_sideband_t pixel_out;
    attr_set_t       attrs_out;
    logic            pixel_in_pipeline;

    attr_plane_set_t plane_model;
    expected_pixel_t expected_q[$];
    int              accept_q[$];
    int              edge_count = 0;
    int              check_count = 0;
    int              error_count = 0;
    logic [31:0]     lfsr_state = 32'h490e_9a2d;

    tb_clock_gen clock_gen (
        .aclk  (aclk),
        .reset (reset)
    );

    attribute_interpolator dut0 (
        .aclk              (aclk),
        .reset             (reset),
        .pixel_in          (pixel_in),
        .planes            (planes),
        .pixel_out         (pixel_out),
        .attrs_out         (attrs_out),
        .pixel_in_pipeline (pixel_in_pipeline)
    );

    always @(posedge aclk) begin
        edge_count <= edge_count + 1;
    end

    ////////////////////////////////////////////////////////////
    // Random numbers and reference model
    ////////////////////////////////////////////////////////////

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] next_random_bits(input int width);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < width; i++) begin
            feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    // Full 64-bit arithmetic, then keep the low 32 bits
    function automatic attr_t interpolate(input attr_plane_t plane, input pos_t bbx,
                                          input pos_t bby);
        longint total;
        total = longint'(plane.base) + longint'(plane.inc_x) * longint'(bbx)
              + longint'(plane.inc_y) * longint'(bby);
        return attr_t'(total[31:0]);
    endfunction

    function automatic attr_plane_t make_plane(input attr_t base, input attr_t inc_x,
                                               input attr_t inc_y);
        attr_plane_t plane;
        plane.base  = base;
        plane.inc_x = inc_x;
        plane.inc_y = inc_y;
        return plane;
    endfunction

    function automatic attr_plane_set_t random_planes();
        attr_plane_set_t result;
        for (int i = 0; i < NUM_ATTRS; i++) begin
            result[i] = make_plane(next_random_bits(32), next_random_bits(32),
                                   next_random_bits(32));
        end
        return result;
    endfunction

    ////////////////////////////////////////////////////////////
    // Checking and end of run
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic report_and_finish();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        error_count++;
        $display("Timeout at %0t ns: %s", $time, what);
        report_and_finish();
    endtask

    // Outputs are stable half a cycle after the rising edge
    always @(negedge aclk) begin : output_monitor
        expected_pixel_t expected;
        int              accepted_edge;
        if (!reset) begin
            // Edge that drove the pixel onto the input
            if (pixel_in.valid) begin
                accept_q.push_back(edge_count);
            end
            if (pixel_out.valid === 1'b1) begin
                if (expected_q.size() == 0 || accept_q.size() == 0) begin
                    error_count++;
                    $display("Unexpected pixel on the output at %0t ns", $time);
                end else begin
                    expected = expected_q.pop_front();
                    accepted_edge = accept_q.pop_front();
                    check_value("pixel_out latency", edge_count - accepted_edge,
                                EXPECTED_LATENCY);
                    check_value("pixel_out.index", pixel_out.index, expected.sideband.index);
                    check_value("pixel_out.spx", pixel_out.spx, expected.sideband.spx);
                    check_value("pixel_out.spy", pixel_out.spy, expected.sideband.spy);
                    check_value("pixel_out.last", pixel_out.last, expected.sideband.last);
                    for (int i = 0; i < NUM_ATTRS; i++) begin
                        check_value($sformatf("attrs_out[%0d]", i), attrs_out[i],
                                    expected.attrs[i]);
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////////////////////////

    task automatic load_planes(input attr_plane_set_t new_planes);
        plane_model = new_planes;
        @(posedge aclk);
        planes <= new_planes;
    endtask

    task automatic drive_pixel(input pos_t bbx, input pos_t bby, input pos_t spx,
                               input pos_t spy, input logic [31:0] index, input logic last);
        pixel_in_t       pixel;
        expected_pixel_t expected;
        pixel.valid = 1'b1;
        pixel.last  = last;
        pixel.bbx   = bbx;
        pixel.bby   = bby;
        pixel.spx   = spx;
        pixel.spy   = spy;
        pixel.index = index;
        expected.sideband.valid = 1'b1;
        expected.sideband.last  = last;
        expected.sideband.spx   = spx;
        expected.sideband.spy   = spy;
        expected.sideband.index = index;
        for (int i = 0; i < NUM_ATTRS; i++) begin
            expected.attrs[i] = interpolate(plane_model[i], bbx, bby);
        end
        @(posedge aclk);
        pixel_in <= pixel;
        expected_q.push_back(expected);
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(posedge aclk);
            pixel_in.valid <= 1'b0;
        end
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge aclk);
            cycles++;
        end
        if (expected_q.size() != 0) begin
            abort_on_timeout("expected pixels did not leave the DUT");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic check_reset_state();
        int cycles;
        cycles = 0;
        do begin
            @(negedge aclk);
            cycles++;
            check_value("pixel_out.valid", pixel_out.valid, 0);
            check_value("pixel_in_pipeline", pixel_in_pipeline, 0);
        end while (reset !== 1'b0 && cycles < RESET_TIMEOUT);
        if (reset !== 1'b0) begin
            abort_on_timeout("reset was never released");
        end
        // Idle pipeline after reset
        repeat (5) begin
            @(negedge aclk);
            check_value("pixel_out.valid", pixel_out.valid, 0);
            check_value("pixel_in_pipeline", pixel_in_pipeline, 0);
        end
    endtask

    task automatic run_single_pixel();
        attr_plane_set_t known;
        known[ATTR_DEPTH_Z] = make_plane(1000, 3, -2);
        known[ATTR_COLOR_R] = make_plane(32'h100, 32'h10, 32'h20);
        known[ATTR_COLOR_G] = make_plane(-50, 7, 9);
        known[ATTR_COLOR_B] = make_plane(0, 1, 1);
        known[ATTR_COLOR_A] = make_plane(32'h7fff_0000, 0, 32'h100);
        load_planes(known);
        drive_pixel(5, 7, 100, 200, 32'h0001_2345, 1'b1);
        drive_idle(1);
        wait_for_drain();
    endtask

    task automatic run_back_to_back_stream();
        load_planes(random_planes());
        for (int i = 0; i < STREAM_LENGTH; i++) begin
            drive_pixel(next_random_bits(SCREEN_POS_WIDTH), next_random_bits(SCREEN_POS_WIDTH),
                        next_random_bits(SCREEN_POS_WIDTH), next_random_bits(SCREEN_POS_WIDTH),
                        next_random_bits(32), i == STREAM_LENGTH - 1);
        end
        drive_idle(1);
        wait_for_drain();
    endtask

    task automatic run_wrap_around();
        attr_plane_set_t extreme;
        extreme[ATTR_DEPTH_Z] = make_plane(32'h7fff_fff0, 32'h8000_0001, -123456789);
        extreme[ATTR_COLOR_R] = make_plane(-1, -1, -1);
        extreme[ATTR_COLOR_G] = make_plane(32'h8000_0000, 32'h7fff_ffff, 32'h0012_3457);
        extreme[ATTR_COLOR_B] = make_plane(0, -2048, 32'hffff_0001);
        extreme[ATTR_COLOR_A] = make_plane(12345, 32'h4000_0000, -3);
        load_planes(extreme);
        drive_pixel(2047, 2047, 2047, 2047, 32'hffff_ffff, 1'b0);
        drive_pixel(2047, 0, 1, 2, 32'h8000_0000, 1'b0);
        drive_pixel(0, 2047, 3, 4, 32'h0000_0000, 1'b0);
        drive_pixel(1024, 1500, 5, 6, 32'h1234_5678, 1'b1);
        drive_idle(1);
        wait_for_drain();
    endtask

    // Gaps of 1 to 3 idle cycles keep the flag high through the burst
    task automatic check_in_flight_flag();
        int   cycles;
        logic last_seen;
        @(negedge aclk);
        check_value("pixel_in_pipeline", pixel_in_pipeline, 0);
        for (int p = 0; p < 4; p++) begin
            drive_pixel(10 * p, 20 * p, p, p, 32'h0000_0100 + p, p == 3);
            @(negedge aclk);
            check_value("pixel_in_pipeline", pixel_in_pipeline, 1);
            repeat ((p == 3) ? 1 : p + 1) begin
                drive_idle(1);
                @(negedge aclk);
                check_value("pixel_in_pipeline", pixel_in_pipeline, 1);
            end
        end
        cycles = 0;
        last_seen = 1'b0;
        while (!last_seen && cycles < DRAIN_TIMEOUT) begin
            @(negedge aclk);
            cycles++;
            check_value("pixel_in_pipeline", pixel_in_pipeline, 1);
            last_seen = (pixel_out.valid === 1'b1) && (pixel_out.last === 1'b1);
        end
        if (!last_seen) begin
            abort_on_timeout("last pixel of the burst never came out");
        end
        repeat (4) begin
            @(negedge aclk);
            check_value("pixel_in_pipeline", pixel_in_pipeline, 0);
        end
    endtask

    initial begin
        pixel_in = '0;
        planes = '0;
        plane_model = '0;
        check_reset_state();
        run_single_pixel();
        run_back_to_back_stream();
        run_wrap_around();
        check_in_flight_flag();
        report_and_finish();
    end

endmodule

/* attribute_interpolator.f */
source/interp_pkg.sv
source/pixel_tracker.sv
source/sideband_delay.sv
source/bbox_step_multiplier.sv
source/attribute_summer.sv
source/attribute_interpolator.sv
tb/tb_clock_gen.sv
tb/tb_attribute_interpolator.sv

/* Makefile */
# Verilator build, run and lint for the attribute interpolator

VERILATOR ?= verilator
FILELIST  ?= attribute_interpolator.f
TB_TOP    ?= tb_attribute_interpolator
RTL_TOP   ?= attribute_interpolator
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
FAIL_MSG  ?= Test FAILED
PASS_MSG  ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator's exit status is not used, the log decides
run: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
